// ==== flist.f ====
rtl/bus_line_pkg.sv
rtl/frame_pkg.sv
rtl/tx_queue.sv
rtl/bit_tx_engine.sv
rtl/pad_driver.sv
rtl/bus_receiver.sv
rtl/discrete_bus_top.sv
verif/tb_clock.sv
verif/discrete_bus_tb.sv

// ==== rtl/bit_tx_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module bit_tx_engine import bus_line_pkg::*, frame_pkg::*; #(
	parameter int CLOCK_DIV = 99
) (
	input  wire         clk,
	input  wire         reset,
	input  wire         tx_req,
	input  wire         queue_entry_t head_entry,
	input  wire         head_valid,
	output logic        pop,
	output line_drive_t scl_drive,
	output line_drive_t sda_drive,
	output logic        phase_start
);

	localparam int CNT_W = $clog2(2 * CLOCK_DIV + 1);
	localparam logic [CNT_W-1:0] PHASE_END = CNT_W'(CLOCK_DIV);
	localparam logic [CNT_W-1:0] START_END = CNT_W'(2 * CLOCK_DIV);

	tx_phase_t phase;
	tx_phase_t next_phase;
	logic [CNT_W-1:0] phase_cnt;
	logic [2:0] bit_idx;
	logic req_pending;
	logic phase_done;
	logic bit_reload;
	logic bit_step;

	assign phase_done = (phase_cnt == PHASE_END);

	always_comb begin
		next_phase = phase;
		pop = 1'b0;
		bit_reload = 1'b0;
		bit_step = 1'b0;
		scl_drive = LINE_FREE;
		sda_drive = LINE_FREE;

		case (phase)
			TX_IDLE: begin
				if (req_pending)
					next_phase = TX_START;
			end

			// SDA falls halfway through with SCL held high
			TX_START: begin
				scl_drive = LINE_HIGH;
				sda_drive = LINE_HIGH;
				bit_reload = 1'b1;
				if (phase_cnt > PHASE_END) begin
					if (head_entry.frame_end) begin
						// Nothing queued for this frame so go straight to stop
						next_phase = TX_STOP1;
					end else begin
						sda_drive = LINE_LOW;
						if (phase_cnt == START_END)
							next_phase = TX_DATA_LOW;
					end
				end
			end

			TX_DATA_LOW: begin
				scl_drive = LINE_LOW;
				sda_drive = '{drive: 1'b1, value: head_entry.data[bit_idx]};
				if (phase_done)
					next_phase = TX_DATA_HIGH;
			end

			TX_DATA_HIGH: begin
				scl_drive = LINE_HIGH;
				sda_drive = '{drive: 1'b1, value: head_entry.data[bit_idx]};
				if (phase_done) begin
					bit_step = 1'b1;
					if (bit_idx == 3'd0)
						next_phase = TX_ACK_LOW;
					else
						next_phase = TX_DATA_LOW;
				end
			end

			// SDA is left to the slave during the acknowledge clock
			TX_ACK_LOW: begin
				scl_drive = LINE_LOW;
				if (phase_done) begin
					pop = head_valid;
					next_phase = TX_ACK_HIGH;
				end
			end

			TX_ACK_HIGH: begin
				scl_drive = LINE_HIGH;
				bit_reload = 1'b1;
				if (phase_done) begin
					if (head_valid && !head_entry.frame_end)
						next_phase = TX_DATA_LOW;
					else
						next_phase = TX_STOP0;
				end
			end

			TX_STOP0: begin
				scl_drive = LINE_LOW;
				sda_drive = LINE_LOW;
				if (phase_done)
					next_phase = TX_STOP1;
			end

			TX_STOP1: begin
				scl_drive = LINE_HIGH;
				sda_drive = LINE_LOW;
				if (phase_done)
					next_phase = TX_STOP2;
			end

			// The frame-end marker leaves the queue here
			TX_STOP2: begin
				scl_drive = LINE_HIGH;
				sda_drive = LINE_HIGH;
				if (phase_done) begin
					pop = head_valid;
					next_phase = TX_IDLE;
				end
			end

			default: next_phase = TX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= TX_IDLE;
			phase_cnt <= '0;
			phase_start <= 1'b0;
			req_pending <= 1'b0;
			bit_idx <= 3'd7;
		end else begin
			phase <= next_phase;
			phase_start <= (next_phase != phase);

			if (next_phase != phase || phase == TX_IDLE)
				phase_cnt <= '0;
			else
				phase_cnt <= phase_cnt + 1'b1;

			// A request arriving on the same cycle as the start is kept for the next frame
			if (tx_req)
				req_pending <= 1'b1;
			else if (phase == TX_IDLE && next_phase == TX_START)
				req_pending <= 1'b0;

			if (bit_reload)
				bit_idx <= 3'd7;
			else if (bit_step)
				bit_idx <= bit_idx - 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (reset) phase_cnt <= START_END)
		else $error("bit_tx_engine: phase counter overran");

endmodule

`default_nettype wire

// ==== rtl/bus_line_pkg.sv ====
`default_nettype none

package bus_line_pkg;

	// Transmit phases of the bit engine, in the order a frame walks through them
	typedef enum logic [3:0] {
		TX_IDLE,
		TX_START,
		TX_DATA_LOW,
		TX_DATA_HIGH,
		TX_ACK_LOW,
		TX_ACK_HIGH,
		TX_STOP0,
		TX_STOP1,
		TX_STOP2
	} tx_phase_t;

	// Receiver states
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_ACK
	} rx_phase_t;

	// One line request from the engine to the pads
	typedef struct packed {
		logic drive;
		logic value;
	} line_drive_t;

	localparam line_drive_t LINE_FREE = '{drive: 1'b0, value: 1'b1};
	localparam line_drive_t LINE_LOW = '{drive: 1'b1, value: 1'b0};
	localparam line_drive_t LINE_HIGH = '{drive: 1'b1, value: 1'b1};

	// The SDA release burst holds the tristate without pull, then pulls up, then lets go
	localparam int SDA_RELEASE_HOLD = 12;
	localparam int SDA_RELEASE_CYCLES = 25;

endpackage

`default_nettype wire

// ==== rtl/bus_receiver.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_receiver import bus_line_pkg::*, frame_pkg::*; (
	input  wire   clk,
	input  wire   reset,
	input  wire   scl_in,
	input  wire   sda_in,
	output char_t rx_char,
	output logic  rx_char_latch,
	output logic  rx_req
);

	rx_phase_t state;
	rx_phase_t next_state;
	logic scl_meta;
	logic scl_sync;
	logic scl_last;
	logic sda_meta;
	logic sda_sync;
	logic sda_last;
	logic [2:0] bit_cnt;
	logic scl_rise;
	logic scl_fall;
	logic stop_seen;
	logic take_bit;

	assign scl_rise = scl_sync && !scl_last;
	assign scl_fall = !scl_sync && scl_last;

	// SDA rising with SCL steady high is a stop condition
	assign stop_seen = sda_sync && !sda_last && scl_sync && scl_last;
	assign take_bit = (state == RX_DATA) && scl_rise && !stop_seen;

	always_comb begin
		next_state = state;
		case (state)
			RX_IDLE: begin
				if (!sda_sync)
					next_state = RX_DATA;
			end

			// A stop can also land here when it follows the second ack fall
			RX_DATA: begin
				if (stop_seen)
					next_state = RX_IDLE;
				else if (scl_rise && bit_cnt == 3'd7)
					next_state = RX_ACK;
			end

			RX_ACK: begin
				if (stop_seen)
					next_state = RX_IDLE;
				else if (scl_fall && bit_cnt == 3'd1)
					next_state = RX_DATA;
			end

			default: next_state = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			scl_meta <= 1'b1;
			scl_sync <= 1'b1;
			scl_last <= 1'b1;
			sda_meta <= 1'b1;
			sda_sync <= 1'b1;
			sda_last <= 1'b1;
			state <= RX_IDLE;
			bit_cnt <= '0;
			rx_char_latch <= 1'b0;
			rx_req <= 1'b0;
		end else begin
			scl_meta <= scl_in;
			scl_sync <= scl_meta;
			scl_last <= scl_sync;
			sda_meta <= sda_in;
			sda_sync <= sda_meta;
			sda_last <= sda_sync;

			state <= next_state;
			if (next_state != state)
				bit_cnt <= '0;
			else if ((state == RX_DATA && scl_rise) || (state == RX_ACK && scl_fall))
				bit_cnt <= bit_cnt + 1'b1;

			rx_char_latch <= take_bit && bit_cnt == 3'd7;
			rx_req <= (state != RX_IDLE) && stop_seen;
		end
	end

	always_ff @(posedge clk) begin
		if (take_bit)
			rx_char <= {rx_char[6:0], sda_sync};
	end

endmodule

`default_nettype wire

// ==== rtl/discrete_bus_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module discrete_bus_top import bus_line_pkg::*, frame_pkg::*; #(
	parameter int CLOCK_DIV = 99,
	parameter int QUEUE_DEPTH_LOG2 = frame_pkg::QUEUE_DEPTH_LOG2
) (
	input  wire   clk,
	input  wire   reset,
	input  wire   scl_in,
	input  wire   sda_in,
	input  wire   char_t tx_char,
	input  wire   tx_char_latch,
	input  wire   tx_req,
	output logic  scl_pd,
	output logic  scl_pu_n,
	output logic  scl_tri,
	output logic  sda_pd,
	output logic  sda_pu_n,
	output logic  sda_tri,
	output char_t rx_char,
	output logic  rx_char_latch,
	output logic  rx_req
);

	queue_entry_t push_entry;
	queue_entry_t head_entry;
	logic push;
	logic head_valid;
	logic pop;
	logic phase_start;
	line_drive_t scl_drive;
	line_drive_t sda_drive;

	// Characters and frame ends share one queue so frames stay in order
	assign push = tx_char_latch || tx_req;
	assign push_entry = '{frame_end: tx_req, data: tx_char};

	tx_queue #(
		.DEPTH_LOG2(QUEUE_DEPTH_LOG2)
	) u_tx_queue (
		.clk(clk),
		.reset(reset),
		.push(push),
		.push_entry(push_entry),
		.pop(pop),
		.head_entry(head_entry),
		.head_valid(head_valid)
	);

	bit_tx_engine #(
		.CLOCK_DIV(CLOCK_DIV)
	) u_bit_tx_engine (
		.clk(clk),
		.reset(reset),
		.tx_req(tx_req),
		.head_entry(head_entry),
		.head_valid(head_valid),
		.pop(pop),
		.scl_drive(scl_drive),
		.sda_drive(sda_drive),
		.phase_start(phase_start)
	);

	pad_driver #(
		.CLOCK_DIV(CLOCK_DIV)
	) u_pad_driver (
		.clk(clk),
		.reset(reset),
		.scl_drive(scl_drive),
		.sda_drive(sda_drive),
		.phase_start(phase_start),
		.scl_pd(scl_pd),
		.scl_pu_n(scl_pu_n),
		.scl_tri(scl_tri),
		.sda_pd(sda_pd),
		.sda_pu_n(sda_pu_n),
		.sda_tri(sda_tri)
	);

	bus_receiver u_bus_receiver (
		.clk(clk),
		.reset(reset),
		.scl_in(scl_in),
		.sda_in(sda_in),
		.rx_char(rx_char),
		.rx_char_latch(rx_char_latch),
		.rx_req(rx_req)
	);

endmodule

`default_nettype wire

// ==== rtl/frame_pkg.sv ====
`default_nettype none

package frame_pkg;

	typedef logic [7:0] char_t;

	// A queue entry is either a character or a frame-end marker
	typedef struct packed {
		logic  frame_end;
		char_t data;
	} queue_entry_t;

	localparam int QUEUE_DEPTH_LOG2 = 4;

endpackage

`default_nettype wire

// ==== rtl/pad_driver.sv ====
`timescale 1ns/10ps
`default_nettype none

module pad_driver import bus_line_pkg::*; #(
	parameter int CLOCK_DIV = 99
) (
	input  wire  clk,
	input  wire  reset,
	input  wire  line_drive_t scl_drive,
	input  wire  line_drive_t sda_drive,
	input  wire  phase_start,
	output logic scl_pd,
	output logic scl_pu_n,
	output logic scl_tri,
	output logic sda_pd,
	output logic sda_pu_n,
	output logic sda_tri
);

	localparam int QUARTER = CLOCK_DIV / 4;
	localparam int QW = $clog2(QUARTER + 2);
	localparam int RW = $clog2(SDA_RELEASE_CYCLES + 1);

	logic [QW-1:0] quarter_cnt;
	logic [QW-1:0] elapsed;
	logic [RW-1:0] release_cnt;
	line_drive_t sda_hold;
	line_drive_t sda_eff;

	// SDA only moves a quarter phase in, which lands it mid SCL low
	assign elapsed = phase_start ? '0 : quarter_cnt;
	assign sda_eff = (elapsed >= QW'(QUARTER)) ? sda_drive : sda_hold;

	always_ff @(posedge clk) begin
		if (reset) begin
			quarter_cnt <= QW'(QUARTER);
			release_cnt <= RW'(SDA_RELEASE_CYCLES);
			sda_hold <= LINE_FREE;
			scl_pd <= 1'b0;
			scl_pu_n <= 1'b1;
			scl_tri <= 1'b0;
			sda_pd <= 1'b0;
			sda_pu_n <= 1'b1;
			sda_tri <= 1'b0;
		end else begin
			if (phase_start)
				quarter_cnt <= QW'(1);
			else if (quarter_cnt < QW'(QUARTER))
				quarter_cnt <= quarter_cnt + 1'b1;

			scl_pd <= scl_drive.drive && !scl_drive.value;
			scl_pu_n <= !(scl_drive.drive && scl_drive.value);
			scl_tri <= scl_drive.drive;

			sda_hold <= sda_eff;
			if (sda_eff.drive) begin
				sda_pd <= !sda_eff.value;
				sda_pu_n <= !sda_eff.value;
				sda_tri <= 1'b1;
				release_cnt <= '0;
			end else if (release_cnt < RW'(SDA_RELEASE_HOLD)) begin
				sda_pd <= 1'b0;
				sda_pu_n <= 1'b1;
				sda_tri <= 1'b1;
				release_cnt <= release_cnt + 1'b1;
			end else if (release_cnt < RW'(SDA_RELEASE_CYCLES)) begin
				// Pull the line up briefly so it does not float low on release
				sda_pd <= 1'b0;
				sda_pu_n <= 1'b0;
				sda_tri <= 1'b1;
				release_cnt <= release_cnt + 1'b1;
			end else begin
				sda_pd <= 1'b0;
				sda_pu_n <= 1'b1;
				sda_tri <= 1'b0;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) !(scl_pd && !scl_pu_n))
		else $error("pad_driver: SCL pull-down and pull-up both on");

	assert property (@(posedge clk) disable iff (reset) !(sda_pd && !sda_pu_n))
		else $error("pad_driver: SDA pull-down and pull-up both on");

endmodule

`default_nettype wire

// ==== rtl/tx_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module tx_queue import frame_pkg::*; #(
	parameter int DEPTH_LOG2 = QUEUE_DEPTH_LOG2
) (
	input  wire          clk,
	input  wire          reset,
	input  wire          push,
	input  wire          queue_entry_t push_entry,
	input  wire          pop,
	output queue_entry_t head_entry,
	output logic         head_valid
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	queue_entry_t mem [DEPTH];
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic [DEPTH_LOG2:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (count == (DEPTH_LOG2 + 1)'(DEPTH));
	assign head_valid = (count != '0);
	assign head_entry = mem[rd_ptr];

	// Pushes into a full queue are lost, pops on an empty one do nothing
	assign do_push = push && !full;
	assign do_pop = pop && head_valid;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_entry;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// The host has no back-pressure, so overflow is a host error
	assert property (@(posedge clk) disable iff (reset) !(push && full))
		else $error("tx_queue: push into full queue dropped");

	// The engine must only consume entries that are present
	assert property (@(posedge clk) disable iff (reset) !(pop && !head_valid))
		else $error("tx_queue: pop from empty queue");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module discrete_bus_tb \
	-o discrete_bus_sim \
	&& ./obj_dir/discrete_bus_sim 2>&1 | tee sim.log \
	|| echo "Simulation build or run error"
grep -qx "Testbench passed" sim.log && exit 0 || exit 1

// ==== verif/discrete_bus_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module discrete_bus_tb import frame_pkg::*;;

	localparam int CLOCK_DIV = 7;
	localparam int NUM_FRAMES = 11;
	localparam int MAX_CHARS = 4;
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * (MAX_CHARS + 1) * 18 * (CLOCK_DIV + 1) + 500;

	logic clk;
	logic reset;
	char_t tx_char;
	logic tx_char_latch;
	logic tx_req;
	wire scl_pd;
	wire scl_pu_n;
	wire scl_tri;
	wire sda_pd;
	wire sda_pu_n;
	wire sda_tri;
	wire [7:0] rx_char;
	wire rx_char_latch;
	wire rx_req;

	logic ack_enable;
	logic ack_pull;
	logic [3:0] slave_bits;
	logic scl_q;
	logic sda_q;
	logic bus_busy;
	logic req_seen;
	logic [31:0] lfsr_state;
	logic [7:0] sent_chars [256];
	logic [7:0] sent_wr;
	logic [7:0] sent_rd = '0;
	int frames_req;
	int frames_done = 0;
	int cycle_count = 0;
	int value_errors = 0;
	int rule_errors = 0;

	// On the open-drain bus a line is low whenever anyone pulls it down
	wire scl_line = !scl_pd;
	wire sda_line = !(sda_pd || ack_pull);
	wire start_cond = scl_q && scl_line && sda_q && !sda_line;
	wire stop_cond = scl_q && scl_line && !sda_q && sda_line;
	wire [7:0] expect_char = sent_chars[sent_rd];
	wire expect_valid = (sent_rd != sent_wr);
	wire [7:0] idle_outputs = {scl_pd, sda_pd, scl_pu_n, sda_pu_n, scl_tri, sda_tri,
		rx_char_latch, rx_req};

	tb_clock #(.PERIOD(8)) u_clock (.clk(clk));

	discrete_bus_top #(
		.CLOCK_DIV(CLOCK_DIV)
	) UUT (
		.clk(clk),
		.reset(reset),
		.scl_in(scl_line),
		.sda_in(sda_line),
		.tx_char(tx_char),
		.tx_char_latch(tx_char_latch),
		.tx_req(tx_req),
		.scl_pd(scl_pd),
		.scl_pu_n(scl_pu_n),
		.scl_tri(scl_tri),
		.sda_pd(sda_pd),
		.sda_pu_n(sda_pu_n),
		.sda_tri(sda_tri),
		.rx_char(rx_char),
		.rx_char_latch(rx_char_latch),
		.rx_req(rx_req)
	);

	always @(posedge clk) begin
		scl_q <= scl_line;
		sda_q <= sda_line;
		if (rx_char_latch && expect_valid)
			sent_rd <= sent_rd + 8'd1;
		if (rx_req)
			frames_done <= frames_done + 1;
	end

	always @(posedge clk) begin
		if (reset)
			bus_busy <= 1'b0;
		else if (start_cond)
			bus_busy <= 1'b1;
		else if (stop_cond)
			bus_busy <= 1'b0;
	end

	// Slave counts eight SCL rises, then holds SDA low for the ninth clock
	always @(posedge clk) begin
		if (reset || start_cond) begin
			slave_bits <= 4'd0;
			ack_pull <= 1'b0;
		end else if (!scl_q && scl_line) begin
			slave_bits <= slave_bits + 4'd1;
		end else if (scl_q && !scl_line) begin
			if (slave_bits == 4'd8)
				ack_pull <= ack_enable;
			if (slave_bits == 4'd9) begin
				ack_pull <= 1'b0;
				slave_bits <= 4'd0;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the frames did not complete within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors: %0d value, %0d protocol", value_errors, rule_errors);
			$display("Testbench failed");
			$finish;
		end
	end

	assert property (@(posedge clk) disable iff (reset) !req_seen |-> idle_outputs == 8'b0011_0000)
	else begin
		value_errors++;
		$display("Fail at %0t: idle outputs expected %b, got %b", $time, 8'b0011_0000,
			$sampled(idle_outputs));
	end

	assert property (@(posedge clk) disable iff (reset) rx_char_latch |-> expect_valid)
	else begin
		rule_errors++;
		$display("A character was received at %0t although none was sent", $time);
	end

	assert property (@(posedge clk) disable iff (reset)
		rx_char_latch && expect_valid |-> rx_char == expect_char)
	else begin
		value_errors++;
		$display("Fail at %0t: rx_char expected %h, got %h", $time, $sampled(expect_char),
			$sampled(rx_char));
	end

	assert property (@(posedge clk) disable iff (reset) rx_req |-> frames_done < frames_req)
	else begin
		rule_errors++;
		$display("An extra stop was reported at %0t", $time);
	end

	assert property (@(posedge clk) disable iff (reset) rx_req |-> !expect_valid)
	else begin
		rule_errors++;
		$display("A frame ended at %0t with characters still missing", $time);
	end

	assert property (@(posedge clk) disable iff (reset) !(scl_pd && !scl_pu_n))
	else begin
		rule_errors++;
		$display("SCL pull-down and pull-up were both on at %0t", $time);
	end

	assert property (@(posedge clk) disable iff (reset) !(sda_pd && !sda_pu_n))
	else begin
		rule_errors++;
		$display("SDA pull-down and pull-up were both on at %0t", $time);
	end

	assert property (@(posedge clk) disable iff (reset) start_cond |-> !bus_busy)
	else begin
		rule_errors++;
		$display("SDA fell while SCL was high inside a frame at %0t", $time);
	end

	assert property (@(posedge clk) disable iff (reset) stop_cond |-> bus_busy && !expect_valid)
	else begin
		rule_errors++;
		$display("SDA rose while SCL was high before the frame was complete at %0t", $time);
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'hA300_0000;
		return state >> 1;
	endfunction

	task automatic random_bits(input int count, output logic [7:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[6:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic expect_bit(input string name, input logic expected, input logic actual);
		assert (actual === expected)
		else begin
			value_errors++;
			$display("Fail at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic expect_count(input string name, input int expected, input int actual);
		assert (actual == expected)
		else begin
			value_errors++;
			$display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic check_bus_released();
		expect_bit("scl_line", 1'b1, scl_line);
		expect_bit("sda_line", 1'b1, sda_line);
		expect_bit("scl_tri", 1'b0, scl_tri);
		expect_bit("sda_tri", 1'b0, sda_tri);
		expect_bit("sda_pu_n", 1'b1, sda_pu_n);
	endtask

	// Queue the characters and the frame end, then wait for the stop to come back
	task automatic send_frame(input int n_chars);
		logic [7:0] c;
		for (int i = 0; i < n_chars; i++) begin
			random_bits(8, c);
			@(posedge clk);
			tx_char <= c;
			tx_char_latch <= 1'b1;
			sent_chars[sent_wr] <= c;
			sent_wr <= sent_wr + 8'd1;
		end
		@(posedge clk);
		tx_char_latch <= 1'b0;
		tx_req <= 1'b1;
		req_seen <= 1'b1;
		frames_req <= frames_req + 1;
		@(posedge clk);
		tx_req <= 1'b0;
		while (!rx_req)
			@(posedge clk);
		repeat (48) @(posedge clk);
		check_bus_released();
	endtask

	initial begin
		logic [7:0] r;
		reset = 1'b1;
		tx_char = '0;
		tx_char_latch = 1'b0;
		tx_req = 1'b0;
		ack_enable = 1'b0;
		req_seen = 1'b0;
		frames_req = 0;
		sent_wr = '0;
		lfsr_state = 32'h5e17_5c50;

		repeat (5) @(posedge clk);
		reset <= 1'b0;
		repeat (20) @(posedge clk);

		send_frame(1);
		send_frame(0);
		for (int f = 0; f < 4; f++) begin
			random_bits(2, r);
			send_frame(2 + r % 3);
		end

		// Same traffic again with a slave acknowledging every character
		ack_enable <= 1'b1;
		send_frame(1);
		for (int f = 0; f < 3; f++) begin
			random_bits(2, r);
			send_frame(2 + r % 3);
		end
		send_frame(0);

		expect_count("frames_done", frames_req, frames_done);
		expect_count("unreceived characters", 0, int'(sent_wr) - int'(sent_rd));
		$display("Errors: %0d value, %0d protocol", value_errors, rule_errors);
		if (value_errors + rule_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire
